// File: files.f
verilog/controlPkg.sv
verilog/instrDecoder.sv
verilog/stateSequencer.sv
verilog/controlWordGen.sv
verilog/controlUnit.sv
sim/controlUnitTb.sv

// File: sim/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;

    // Instruction classes as seen from opcode and funct
    typedef enum int {
        clsAdd, clsSub, clsAnd, clsJr, clsMfhi, clsMflo, clsMult, clsDiv,
        clsJump, clsImm, clsBeq, clsBne, clsBle, clsBgt, clsBad
    } instrClass_e;

    // 6 ALU + 2 imm + 2 jumps + 16 branches + 6 mult/div + 2 moves + 2 unknown
    localparam int instrCount = 36;

    logic                               clock;
    logic                               rstN;
    logic [controlPkg::opcodeWidth-1:0] opcode;
    logic [controlPkg::functWidth-1:0]  funct;
    controlPkg::aluFlags_t              flags;
    logic                               multDone;
    logic                               divDone;
    controlPkg::controlWord_t           ctrl;
    controlPkg::state_e                 state;

    controlPkg::state_e predState;
    integer             seed = 32'h3e3d_1f95;

    controlUnit UUT (
        .clock    (clock),
        .rstN     (rstN),
        .opcode   (opcode),
        .funct    (funct),
        .flags    (flags),
        .multDone (multDone),
        .divDone  (divDone),
        .ctrl     (ctrl),
        .state    (state)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic stopRun();
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, actual,
                     expected);
            stopRun();
        end
    endtask

    function automatic instrClass_e classify(input logic [5:0] op, input logic [5:0] fn);
        instrClass_e k;
        k = clsBad;
        case (op)
            controlPkg::opRType: begin
                case (fn)
                    controlPkg::fnAdd:   k = clsAdd;
                    controlPkg::fnSub:   k = clsSub;
                    controlPkg::fnAndOp: k = clsAnd;
                    controlPkg::fnJr:    k = clsJr;
                    controlPkg::fnMfhi:  k = clsMfhi;
                    controlPkg::fnMflo:  k = clsMflo;
                    controlPkg::fnMult:  k = clsMult;
                    controlPkg::fnDiv:   k = clsDiv;
                    default:             k = clsBad;
                endcase
            end
            controlPkg::opJump:  k = clsJump;
            controlPkg::opAddi:  k = clsImm;
            controlPkg::opAddiu: k = clsImm;
            controlPkg::opBeq:   k = clsBeq;
            controlPkg::opBne:   k = clsBne;
            controlPkg::opBle:   k = clsBle;
            controlPkg::opBgt:   k = clsBgt;
            default:             k = clsBad;
        endcase
        return k;
    endfunction

    function automatic controlPkg::controlWord_t expectedWord(
        input controlPkg::state_e st, input logic [5:0] op, input logic [5:0] fn,
        input controlPkg::aluFlags_t fl);
        controlPkg::controlWord_t w;
        instrClass_e k;
        logic taken;
        w = '0;
        k = classify(op, fn);
        taken = (k == clsBeq && fl.eq) || (k == clsBne && !fl.eq) ||
                (k == clsBle && !fl.gt) || (k == clsBgt && fl.gt);
        case (st)
            controlPkg::fetch1: begin
                w.pc.pcWrite = 1'b1;
                w.pc.pcSource = controlPkg::pcAluResult;
                w.alu.aluOp = controlPkg::aluAdd;
                w.alu.aluSrcB = controlPkg::srcBFour;
            end
            controlPkg::fetch3: begin
                w.regs.irWrite = 1'b1;
            end
            controlPkg::decode: begin
                w.alu.aluOp = controlPkg::aluAdd;
                w.alu.aluSrcB = controlPkg::srcBBranchOffset;
                w.regs.regAWrite = 1'b1;
                w.regs.regBWrite = 1'b1;
                w.regs.aluOutWrite = 1'b1;
            end
            controlPkg::execute: begin
                case (k)
                    clsAdd, clsSub, clsAnd: begin
                        w.alu.aluOp = (k == clsAdd) ? controlPkg::aluAdd :
                                      (k == clsSub) ? controlPkg::aluSub : controlPkg::aluAnd;
                        w.alu.aluSrcA = 1'b1;
                        w.alu.aluSrcB = controlPkg::srcBRegB;
                        w.regs.aluOutWrite = 1'b1;
                    end
                    clsImm: begin
                        w.alu.aluOp = controlPkg::aluAdd;
                        w.alu.aluSrcA = 1'b1;
                        w.alu.aluSrcB = controlPkg::srcBSignExtImm;
                        w.regs.aluOutWrite = 1'b1;
                    end
                    clsJr: begin
                        w.pc.pcWrite = 1'b1;
                        w.pc.pcSource = controlPkg::pcRegA;
                    end
                    clsJump: begin
                        w.pc.pcWrite = 1'b1;
                        w.pc.pcSource = controlPkg::pcJumpTarget;
                    end
                    clsMult: w.hiLo.multStart = 1'b1;
                    clsDiv:  w.hiLo.divStart = 1'b1;
                    clsBeq, clsBne, clsBle, clsBgt: begin
                        w.pc.pcSource = controlPkg::pcBranchTarget;
                        w.alu.aluOp = controlPkg::aluCompare;
                        w.alu.aluSrcA = 1'b1;
                        w.alu.aluSrcB = controlPkg::srcBRegB;
                    end
                    default: w = '0;
                endcase
            end
            controlPkg::aluWrite: begin
                w.regs.regWrite = !fl.overflow;
                w.regs.regDest = controlPkg::destRdField;
                w.regs.regData = controlPkg::dataAluResult;
            end
            controlPkg::immWrite: begin
                w.regs.regWrite = 1'b1;
                if (k == clsMfhi || k == clsMflo) begin
                    w.regs.regDest = controlPkg::destRdField;
                    w.regs.regData = controlPkg::dataHiLo;
                    w.hiLo.hiLoSelect = (k == clsMflo);
                end else begin
                    w.regs.regDest = controlPkg::destRtField;
                    w.regs.regData = controlPkg::dataAluOut;
                end
            end
            controlPkg::hiLoWrite: begin
                w.hiLo.hiWrite = 1'b1;
                w.hiLo.loWrite = 1'b1;
                w.hiLo.hiLoFromDiv = (k == clsDiv);
            end
            controlPkg::branchResolve: begin
                w.pc.pcWrite = taken;
                w.pc.pcSource = controlPkg::pcBranchTarget;
                w.alu.aluOp = controlPkg::aluCompare;
                w.alu.aluSrcA = 1'b1;
                w.alu.aluSrcB = controlPkg::srcBRegB;
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    function automatic controlPkg::state_e predictNext(input controlPkg::state_e st,
                                                       input instrClass_e k,
                                                       input logic mDone, input logic dDone);
        case (st)
            controlPkg::fetch1: return controlPkg::fetch2;
            controlPkg::fetch2: return controlPkg::fetch3;
            controlPkg::fetch3: return controlPkg::decode;
            controlPkg::decode: return controlPkg::execute;
            controlPkg::execute: begin
                case (k)
                    clsAdd, clsSub, clsAnd:         return controlPkg::aluWrite;
                    clsImm, clsMfhi, clsMflo:       return controlPkg::immWrite;
                    clsMult:                        return controlPkg::mulWait;
                    clsDiv:                         return controlPkg::divWait;
                    clsBeq, clsBne, clsBle, clsBgt: return controlPkg::branchResolve;
                    default:                        return controlPkg::waitState;
                endcase
            end
            controlPkg::mulWait: return mDone ? controlPkg::hiLoWrite : controlPkg::mulWait;
            controlPkg::divWait: return dDone ? controlPkg::hiLoWrite : controlPkg::divWait;
            controlPkg::waitState: return controlPkg::fetch1;
            default: return controlPkg::waitState;
        endcase
    endfunction

    function automatic int expectedCycles(input instrClass_e k, input int delay);
        case (k)
            clsJump, clsJr, clsBad: return 6;
            clsMult, clsDiv:        return 7 + delay;
            default:                return 7;
        endcase
    endfunction

    // Entered on a falling edge in fetch1, leaves on the next fetch1
    task automatic runInstr(input logic [5:0] op, input logic [5:0] fn,
                            input controlPkg::aluFlags_t fl);
        instrClass_e k;
        int cycles;
        int waited;
        int delay;
        int multStarts;
        int divStarts;
        bit finished;
        k = classify(op, fn);
        cycles = 0;
        waited = 0;
        multStarts = 0;
        divStarts = 0;
        finished = 1'b0;
        delay = ($random(seed) & 7) + 1;
        opcode = op;
        funct = fn;
        flags = fl;
        while (!finished) begin
            cycles = cycles + 1;
            multStarts = multStarts + ctrl.hiLo.multStart;
            divStarts = divStarts + ctrl.hiLo.divStart;
            if (state == controlPkg::mulWait || state == controlPkg::divWait) begin
                waited = waited + 1;
            end
            multDone = (state == controlPkg::mulWait) && (waited >= delay);
            divDone = (state == controlPkg::divWait) && (waited >= delay);
            if (state == controlPkg::waitState) begin
                finished = 1'b1;
            end else if (cycles >= 40) begin
                $display("error at %0t ns: instruction never reached the wait state", $time);
                stopRun();
            end else begin
                @(negedge clock);
            end
        end
        checkValue(cycles, expectedCycles(k, delay), "cycles from fetch1 to waitState");
        checkValue(multStarts, (k == clsMult), "multStart pulses");
        checkValue(divStarts, (k == clsDiv), "divStart pulses");
        @(negedge clock);
    endtask

    // Sampled on the rising edge, before the state register moves
    always @(posedge clock) begin
        if (!rstN) begin
            checkValue(state, controlPkg::fetch1, "state during reset");
            predState = controlPkg::fetch1;
        end else begin
            checkValue(state, predState, "state");
            checkValue(ctrl, expectedWord(predState, opcode, funct, flags), "control word");
            predState = predictNext(predState, classify(opcode, funct), multDone, divDone);
        end
    end

    initial begin
        repeat (instrCount * 20 + 16) @(posedge clock);
        $display("error at %0t ns: watchdog expired before all instructions finished", $time);
        stopRun();
    end

    initial begin
        logic [5:0] aluFuncts [3];
        logic [5:0] branchOps [4];
        integer randomBits;
        aluFuncts = '{controlPkg::fnAdd, controlPkg::fnSub, controlPkg::fnAndOp};
        branchOps = '{controlPkg::opBeq, controlPkg::opBne, controlPkg::opBle,
                      controlPkg::opBgt};
        rstN = 1'b0;
        opcode = '0;
        funct = '0;
        flags = '0;
        multDone = 1'b0;
        divDone = 1'b0;
        repeat (16) @(negedge clock);
        rstN = 1'b1;
        checkValue(state, controlPkg::fetch1, "state after reset");

        for (int i = 0; i < 3; i++) begin
            runInstr(controlPkg::opRType, aluFuncts[i], 3'b000);
            runInstr(controlPkg::opRType, aluFuncts[i], 3'b100);
        end

        // ADDIU writes even when the ALU flags an overflow
        runInstr(controlPkg::opAddi, 6'b000000, 3'b000);
        runInstr(controlPkg::opAddiu, 6'b101010, 3'b100);
        runInstr(controlPkg::opJump, 6'b000000, 3'b000);
        runInstr(controlPkg::opRType, controlPkg::fnJr, 3'b000);

        // Each branch under every EQ/GT pair
        for (int b = 0; b < 4; b++) begin
            for (int f = 0; f < 4; f++) begin
                runInstr(branchOps[b], 6'b000000, {1'b0, f[1:0]});
            end
        end

        for (int i = 0; i < 3; i++) begin
            randomBits = $random(seed);
            runInstr(controlPkg::opRType, controlPkg::fnMult, randomBits[2:0]);
            randomBits = $random(seed);
            runInstr(controlPkg::opRType, controlPkg::fnDiv, randomBits[2:0]);
        end
        runInstr(controlPkg::opRType, controlPkg::fnMfhi, 3'b000);
        runInstr(controlPkg::opRType, controlPkg::fnMflo, 3'b000);

        runInstr(controlPkg::opRType, 6'b000001, 3'b000);
        runInstr(6'b111111, controlPkg::fnAdd, 3'b000);

        repeat (2) @(negedge clock);
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: verilog/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic                               clock,
    input  logic                               rstN,
    input  logic [controlPkg::opcodeWidth-1:0] opcode,
    input  logic [controlPkg::functWidth-1:0]  funct,
    input  controlPkg::aluFlags_t              flags,
    input  logic                               multDone,
    input  logic                               divDone,
    output controlPkg::controlWord_t           ctrl,
    output controlPkg::state_e                 state
);

    controlPkg::instrKind_e kind;

    instrDecoder decoder (
        .opcode (opcode),
        .funct  (funct),
        .kind   (kind)
    );

    stateSequencer sequencer (
        .clock    (clock),
        .rstN     (rstN),
        .kind     (kind),
        .multDone (multDone),
        .divDone  (divDone),
        .state    (state)
    );

    controlWordGen wordGen (
        .state (state),
        .kind  (kind),
        .flags (flags),
        .ctrl  (ctrl)
    );

endmodule

// File: verilog/controlWordGen.sv
`timescale 1ns/1ps

module controlWordGen (
    input  controlPkg::state_e       state,
    input  controlPkg::instrKind_e   kind,
    input  controlPkg::aluFlags_t    flags,
    output controlPkg::controlWord_t ctrl
);

    logic branchTaken;

    always_comb begin
        case (kind)
            controlPkg::kindBeq: begin
                branchTaken = flags.eq;
            end
            controlPkg::kindBne: begin
                branchTaken = !flags.eq;
            end
            controlPkg::kindBle: begin
                branchTaken = !flags.gt;
            end
            controlPkg::kindBgt: begin
                branchTaken = flags.gt;
            end
            default: begin
                branchTaken = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl = controlPkg::ctrlIdle;
        case (state)
            controlPkg::fetch1: begin
                // PC + 4
                ctrl.pc.pcWrite = 1'b1;
                ctrl.pc.pcSource = controlPkg::pcAluResult;
                ctrl.alu.aluOp = controlPkg::aluAdd;
                ctrl.alu.aluSrcB = controlPkg::srcBFour;
            end
            controlPkg::fetch3: begin
                ctrl.regs.irWrite = 1'b1;
            end
            controlPkg::decode: begin
                // Branch target computed early into ALUOut
                ctrl.alu.aluOp = controlPkg::aluAdd;
                ctrl.alu.aluSrcB = controlPkg::srcBBranchOffset;
                ctrl.regs.regAWrite = 1'b1;
                ctrl.regs.regBWrite = 1'b1;
                ctrl.regs.aluOutWrite = 1'b1;
            end
            controlPkg::execute: begin
                case (kind)
                    controlPkg::kindAdd,
                    controlPkg::kindSub,
                    controlPkg::kindAnd: begin
                        if (kind == controlPkg::kindAdd) begin
                            ctrl.alu.aluOp = controlPkg::aluAdd;
                        end else if (kind == controlPkg::kindSub) begin
                            ctrl.alu.aluOp = controlPkg::aluSub;
                        end else begin
                            ctrl.alu.aluOp = controlPkg::aluAnd;
                        end
                        ctrl.alu.aluSrcA = 1'b1;
                        ctrl.alu.aluSrcB = controlPkg::srcBRegB;
                        ctrl.regs.aluOutWrite = 1'b1;
                    end
                    controlPkg::kindAddImm: begin
                        ctrl.alu.aluOp = controlPkg::aluAdd;
                        ctrl.alu.aluSrcA = 1'b1;
                        ctrl.alu.aluSrcB = controlPkg::srcBSignExtImm;
                        ctrl.regs.aluOutWrite = 1'b1;
                    end
                    controlPkg::kindJr: begin
                        ctrl.pc.pcWrite = 1'b1;
                        ctrl.pc.pcSource = controlPkg::pcRegA;
                    end
                    controlPkg::kindJump: begin
                        ctrl.pc.pcWrite = 1'b1;
                        ctrl.pc.pcSource = controlPkg::pcJumpTarget;
                    end
                    controlPkg::kindMult: begin
                        ctrl.hiLo.multStart = 1'b1;
                    end
                    controlPkg::kindDiv: begin
                        ctrl.hiLo.divStart = 1'b1;
                    end
                    controlPkg::kindBeq,
                    controlPkg::kindBne,
                    controlPkg::kindBle,
                    controlPkg::kindBgt: begin
                        ctrl.pc.pcSource = controlPkg::pcBranchTarget;
                        ctrl.alu.aluOp = controlPkg::aluCompare;
                        ctrl.alu.aluSrcA = 1'b1;
                        ctrl.alu.aluSrcB = controlPkg::srcBRegB;
                    end
                    default: begin
                        ctrl = controlPkg::ctrlIdle;
                    end
                endcase
            end
            controlPkg::aluWrite: begin
                // Overflow drops the result
                ctrl.regs.regWrite = !flags.overflow;
                ctrl.regs.regDest = controlPkg::destRdField;
                ctrl.regs.regData = controlPkg::dataAluResult;
            end
            controlPkg::immWrite: begin
                ctrl.regs.regWrite = 1'b1;
                if (kind == controlPkg::kindMfhi || kind == controlPkg::kindMflo) begin
                    ctrl.regs.regDest = controlPkg::destRdField;
                    ctrl.regs.regData = controlPkg::dataHiLo;
                    ctrl.hiLo.hiLoSelect = (kind == controlPkg::kindMflo);
                end else begin
                    ctrl.regs.regDest = controlPkg::destRtField;
                    ctrl.regs.regData = controlPkg::dataAluOut;
                end
            end
            controlPkg::hiLoWrite: begin
                ctrl.hiLo.hiWrite = 1'b1;
                ctrl.hiLo.loWrite = 1'b1;
                ctrl.hiLo.hiLoFromDiv = (kind == controlPkg::kindDiv);
            end
            controlPkg::branchResolve: begin
                // Compare still running so EQ and GT are valid this cycle
                ctrl.pc.pcWrite = branchTaken;
                ctrl.pc.pcSource = controlPkg::pcBranchTarget;
                ctrl.alu.aluOp = controlPkg::aluCompare;
                ctrl.alu.aluSrcA = 1'b1;
                ctrl.alu.aluSrcB = controlPkg::srcBRegB;
            end
            default: begin
                ctrl = controlPkg::ctrlIdle;
            end
        endcase
    end

endmodule

// File: verilog/stateSequencer.sv
`timescale 1ns/1ps

module stateSequencer (
    input  logic                   clock,
    input  logic                   rstN,
    input  controlPkg::instrKind_e kind,
    input  logic                   multDone,
    input  logic                   divDone,
    output controlPkg::state_e     state
);

    controlPkg::state_e nextState;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= controlPkg::fetch1;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = controlPkg::fetch1;
        case (state)
            controlPkg::fetch1: begin
                nextState = controlPkg::fetch2;
            end
            controlPkg::fetch2: begin
                nextState = controlPkg::fetch3;
            end
            controlPkg::fetch3: begin
                nextState = controlPkg::decode;
            end
            controlPkg::decode: begin
                nextState = controlPkg::execute;
            end
            controlPkg::execute: begin
                // Completion state per instruction, jumps finish here
                case (kind)
                    controlPkg::kindAdd,
                    controlPkg::kindSub,
                    controlPkg::kindAnd: begin
                        nextState = controlPkg::aluWrite;
                    end
                    controlPkg::kindAddImm,
                    controlPkg::kindMfhi,
                    controlPkg::kindMflo: begin
                        nextState = controlPkg::immWrite;
                    end
                    controlPkg::kindMult: begin
                        nextState = controlPkg::mulWait;
                    end
                    controlPkg::kindDiv: begin
                        nextState = controlPkg::divWait;
                    end
                    controlPkg::kindBeq,
                    controlPkg::kindBne,
                    controlPkg::kindBle,
                    controlPkg::kindBgt: begin
                        nextState = controlPkg::branchResolve;
                    end
                    default: begin
                        nextState = controlPkg::waitState;
                    end
                endcase
            end
            controlPkg::mulWait: begin
                if (multDone) begin
                    nextState = controlPkg::hiLoWrite;
                end else begin
                    nextState = controlPkg::mulWait;
                end
            end
            controlPkg::divWait: begin
                if (divDone) begin
                    nextState = controlPkg::hiLoWrite;
                end else begin
                    nextState = controlPkg::divWait;
                end
            end
            controlPkg::aluWrite,
            controlPkg::immWrite,
            controlPkg::hiLoWrite,
            controlPkg::branchResolve: begin
                nextState = controlPkg::waitState;
            end
            controlPkg::waitState: begin
                nextState = controlPkg::fetch1;
            end
            default: begin
                nextState = controlPkg::fetch1;
            end
        endcase
    end

endmodule

// File: verilog/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic [controlPkg::opcodeWidth-1:0] opcode,
    input  logic [controlPkg::functWidth-1:0]  funct,
    output controlPkg::instrKind_e             kind
);

    controlPkg::instrKind_e rTypeKind;

    // Funct only matters for R-type
    always_comb begin
        case (funct)
            controlPkg::fnAdd: begin
                rTypeKind = controlPkg::kindAdd;
            end
            controlPkg::fnSub: begin
                rTypeKind = controlPkg::kindSub;
            end
            controlPkg::fnAndOp: begin
                rTypeKind = controlPkg::kindAnd;
            end
            controlPkg::fnJr: begin
                rTypeKind = controlPkg::kindJr;
            end
            controlPkg::fnMfhi: begin
                rTypeKind = controlPkg::kindMfhi;
            end
            controlPkg::fnMflo: begin
                rTypeKind = controlPkg::kindMflo;
            end
            controlPkg::fnMult: begin
                rTypeKind = controlPkg::kindMult;
            end
            controlPkg::fnDiv: begin
                rTypeKind = controlPkg::kindDiv;
            end
            default: begin
                rTypeKind = controlPkg::kindUnknown;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            controlPkg::opRType: begin
                kind = rTypeKind;
            end
            controlPkg::opJump: begin
                kind = controlPkg::kindJump;
            end
            controlPkg::opAddi,
            controlPkg::opAddiu: begin
                kind = controlPkg::kindAddImm;
            end
            controlPkg::opBeq: begin
                kind = controlPkg::kindBeq;
            end
            controlPkg::opBne: begin
                kind = controlPkg::kindBne;
            end
            controlPkg::opBle: begin
                kind = controlPkg::kindBle;
            end
            controlPkg::opBgt: begin
                kind = controlPkg::kindBgt;
            end
            default: begin
                kind = controlPkg::kindUnknown;
            end
        endcase
    end

endmodule

// File: verilog/controlPkg.sv
package controlPkg;

    localparam int opcodeWidth = 6;
    localparam int functWidth = 6;

    typedef enum logic [opcodeWidth-1:0] {
        opRType = 6'b000000,
        opJump  = 6'b000010,
        opBeq   = 6'b000100,
        opBne   = 6'b000101,
        opBle   = 6'b000110,
        opBgt   = 6'b000111,
        opAddi  = 6'b001000,
        opAddiu = 6'b001001
    } opcode_e;

    // R-type funct field
    typedef enum logic [functWidth-1:0] {
        fnJr    = 6'b001000,
        fnMfhi  = 6'b010000,
        fnMflo  = 6'b010010,
        fnMult  = 6'b011000,
        fnDiv   = 6'b011010,
        fnAdd   = 6'b100000,
        fnSub   = 6'b100010,
        fnAndOp = 6'b100100
    } funct_e;

    // ADDI and ADDIU share one kind
    typedef enum logic [3:0] {
        kindAdd,
        kindSub,
        kindAnd,
        kindJr,
        kindMfhi,
        kindMflo,
        kindMult,
        kindDiv,
        kindJump,
        kindAddImm,
        kindBeq,
        kindBne,
        kindBle,
        kindBgt,
        kindUnknown
    } instrKind_e;

    typedef enum logic [3:0] {
        fetch1,
        fetch2,
        fetch3,
        decode,
        execute,
        aluWrite,
        immWrite,
        mulWait,
        divWait,
        hiLoWrite,
        branchResolve,
        waitState
    } state_e;

    typedef enum logic [2:0] {
        pcAluResult    = 3'b001,
        pcBranchTarget = 3'b100,
        pcJumpTarget   = 3'b101,
        pcRegA         = 3'b111
    } pcSource_e;

    typedef enum logic [2:0] {
        aluLoad    = 3'b000,
        aluAdd     = 3'b001,
        aluSub     = 3'b010,
        aluAnd     = 3'b011,
        aluCompare = 3'b111
    } aluOp_e;

    typedef enum logic [2:0] {
        srcBRegB         = 3'b000,
        srcBSignExtImm   = 3'b010,
        srcBFour         = 3'b011,
        srcBBranchOffset = 3'b101
    } aluSrcB_e;

    typedef enum logic [2:0] {
        destRtField = 3'b000,
        destRdField = 3'b001
    } regDest_e;

    typedef enum logic [3:0] {
        dataAluOut    = 4'b0000,
        dataHiLo      = 4'b0001,
        dataAluResult = 4'b1001
    } regData_e;

    typedef struct packed {
        logic      pcWrite;
        pcSource_e pcSource;
    } pcCtrl_t;

    typedef struct packed {
        aluOp_e   aluOp;
        logic     aluSrcA;
        aluSrcB_e aluSrcB;
    } aluCtrl_t;

    typedef struct packed {
        logic     irWrite;
        logic     regAWrite;
        logic     regBWrite;
        logic     aluOutWrite;
        logic     regWrite;
        regDest_e regDest;
        regData_e regData;
    } regCtrl_t;

    // hiLoSelect picks LO when set, hiLoFromDiv picks the divider result
    typedef struct packed {
        logic multStart;
        logic divStart;
        logic hiWrite;
        logic loWrite;
        logic hiLoSelect;
        logic hiLoFromDiv;
    } hiLoCtrl_t;

    typedef struct packed {
        pcCtrl_t   pc;
        aluCtrl_t  alu;
        regCtrl_t  regs;
        hiLoCtrl_t hiLo;
    } controlWord_t;

    typedef struct packed {
        logic overflow;
        logic eq;
        logic gt;
    } aluFlags_t;

    // No strobes, every select at zero
    localparam controlWord_t ctrlIdle = '0;

endpackage
